/* logic/cube_config.svh */
// cube geometry, serial bit counts and ws2812 pulse cycle counts
`ifndef CUBE_CONFIG_SVH
`define CUBE_CONFIG_SVH

// cube layout
`define CUBE_FACES      6     // one panel per face
`define FACE_SQUARES    9     // 3x3 stickers
`define SQUARE_BITS     3     // colour code per sticker
`define CUBE_BITS       162   // full serial load
`define FACE_BITS       27    // squares * code width

// panel layout
`define PANEL_SIZE      8     // 8x8 leds
`define DIVIDER_A       2     // first blank row/col
`define DIVIDER_B       5     // second blank row/col
`define COLOR_BITS      24    // one led colour word

// ws2812 timing in clk cycles
`define T0H_CYCLES      16
`define T0L_CYCLES      34
`define T1H_CYCLES      32
`define T1L_CYCLES      18
`define LATCH_CYCLES    2000  // end of frame reset gap
`define PULSE_CNT_BITS  11    // holds LATCH_CYCLES

`endif

/* logic/cube_pkg.sv */
// shared types: face word, cube state union, pixel position and pixel command
`default_nettype none

package cube_pkg;

`include "cube_config.svh"

	//////////////////////////////////////////////////////////////
	// cube state
	//////////////////////////////////////////////////////////////

	// square k sits at bits 3k+2 .. 3k
	typedef logic [`FACE_SQUARES-1:0][`SQUARE_BITS-1:0] face_t;

	// same 162 bits seen as the raw shift word or as six faces
	typedef union packed {
		logic [`CUBE_BITS-1:0]        flat;   // filled by the receiver, first bit at msb
		face_t [`CUBE_FACES-1:0]      faces;  // face f at bits 27f+26 .. 27f
	} cube_state_u;

	//////////////////////////////////////////////////////////////
	// pixel walk
	//////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [3:0] col;  // 0..7, panel column
		logic [3:0] row;  // 0..7, already serpentine adjusted
	} pixel_pos_t;

	// one led word handed to the encoder
	typedef struct packed {
		logic [`COLOR_BITS-1:0] color;  // sent bit 0 first
		logic                   last;   // final pixel of face 5, latch gap follows
	} pixel_cmd_t;

endpackage

`default_nettype wire

/* logic/cube_spi_rx.sv */
// serial receiver: sck/sdi/load synchronisers, 162-bit shifter, bit counter, held cube state
`timescale 1ns/1ps
`default_nettype none
`include "cube_config.svh"

module cube_spi_rx (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sck,
	input  logic                  sdi,
	input  logic                  load,
	input  logic                  busy,         // frame in progress, loads are dropped
	output cube_pkg::cube_state_u cube_state,
	output logic                  frame_start
);

	logic [1:0]            sck_sync, sdi_sync, load_sync;  // two flop synchronisers
	logic                  sck_prev, load_prev;            // for edge detect
	logic                  sck_rise, load_fall, accept;
	logic [`CUBE_BITS-1:0] shift_word;
	logic [7:0]            bit_cnt;                        // saturates at 255

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync  <= '0;
			sdi_sync  <= '0;
			load_sync <= '0;
			sck_prev  <= 1'b0;
			load_prev <= 1'b0;
		end else begin
			sck_sync  <= {sck_sync[0], sck};
			sdi_sync  <= {sdi_sync[0], sdi};
			load_sync <= {load_sync[0], load};
			sck_prev  <= sck_sync[1];
			load_prev <= load_sync[1];
		end
	end

	assign sck_rise  = sck_sync[1] & ~sck_prev;
	assign load_fall = ~load_sync[1] & load_prev;
	// only an exact length load starts a frame
	assign accept    = load_fall && (bit_cnt == `CUBE_BITS) && !busy;

	// counts every edge while load is high so overlong loads are caught
	always_ff @(posedge clk) begin
		if (reset || !load_sync[1])
			bit_cnt <= '0;
		else if (sck_rise && bit_cnt != 8'hff)
			bit_cnt <= bit_cnt + 8'd1;
	end

	// shift in at the low end, bits past the 162nd are ignored
	always_ff @(posedge clk) begin
		if (load_sync[1] && sck_rise && bit_cnt < `CUBE_BITS)
			shift_word <= {shift_word[`CUBE_BITS-2:0], sdi_sync[1]};
	end

	always_ff @(posedge clk) begin
		if (accept)
			cube_state.flat <= shift_word;  // stays put until the next good load
	end

	always_ff @(posedge clk) begin
		if (reset)
			frame_start <= 1'b0;
		else
			frame_start <= accept;  // one cycle after the load fall
	end

endmodule

`default_nettype wire

/* logic/frame_sequencer.sv */
// frame FSM: face counter, serpentine pixel walk and pixel start / last flag generation
`timescale 1ns/1ps
`default_nettype none
`include "cube_config.svh"

module frame_sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  frame_start,
	input  logic                  pixel_done,   // encoder finished current pixel
	input  cube_pkg::cube_state_u cube_state,
	output cube_pkg::face_t       face,
	output cube_pkg::pixel_pos_t  pos,
	output logic                  pixel_start,
	output logic                  busy,
	output logic                  cmd_last
);

	localparam int last_pix  = `PANEL_SIZE * `PANEL_SIZE - 1;  // 63
	localparam int last_face = `CUBE_FACES - 1;                // 5

	typedef enum logic [1:0] {
		idle,       // no frame, waiting for frame_start
		issue,      // one cycle, pixel_start high
		wait_done   // encoder busy with the pixel
	} state_t;

	state_t     state;
	logic [2:0] face_cnt;
	logic [5:0] pix_cnt;    // p = 8*col + (serpentine row)
	logic       pix_end;

	assign pix_end = (pix_cnt == 6'(last_pix));

	////////////////////////////////////////////////////////////
	// state and walk counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= idle;
			face_cnt <= '0;
			pix_cnt  <= '0;
		end else begin
			case (state)
				idle: begin
					if (frame_start) begin
						state    <= issue;
						face_cnt <= '0;  // face 0 first
						pix_cnt  <= '0;
					end
				end
				issue: state <= wait_done;
				wait_done: begin
					if (pixel_done) begin
						if (cmd_last) begin
							state <= idle;  // latch gap already sent by encoder
						end else begin
							state   <= issue;  // next start one cycle after done
							pix_cnt <= pix_cnt + 6'd1;  // wraps 63 -> 0
							if (pix_end)
								face_cnt <= face_cnt + 3'd1;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////

	// column is p/8, odd columns run bottom up
	assign pos.col = {1'b0, pix_cnt[5:3]};
	assign pos.row = pix_cnt[3] ? {1'b0, ~pix_cnt[2:0]} : {1'b0, pix_cnt[2:0]};

	assign face = cube_state.faces[face_cnt];

	assign pixel_start = (state == issue);
	assign busy        = (state != idle);
	assign cmd_last    = pix_end && (face_cnt == 3'(last_face));  // 384th pixel

endmodule

`default_nettype wire

/* logic/square_color_map.sv */
// pixel position to square index, square code to 24-bit grb colour
`timescale 1ns/1ps
`default_nettype none
`include "cube_config.svh"

module square_color_map (
	input  cube_pkg::face_t      face,
	input  cube_pkg::pixel_pos_t pos,
	output logic [23:0]          color
);

	logic                     blank;
	logic [1:0]               blk_col, blk_row;  // 2x2 block coordinates, 0..2
	logic [3:0]               sq_idx;            // 0..8
	logic [`SQUARE_BITS-1:0]  code;

	// divider lines between the 2x2 blocks stay dark
	assign blank = (pos.row == `DIVIDER_A) || (pos.row == `DIVIDER_B) ||
	               (pos.col == `DIVIDER_A) || (pos.col == `DIVIDER_B);

	// each block plus its divider is 3 leds wide
	assign blk_col = 2'(pos.col / 4'd3);
	assign blk_row = 2'(pos.row / 4'd3);

	// squares follow the same serpentine as the leds
	always_comb begin
		if (blk_col[0])
			sq_idx = 4'd3 * {2'b00, blk_col} + 4'd2 - {2'b00, blk_row};
		else
			sq_idx = 4'd3 * {2'b00, blk_col} + {2'b00, blk_row};
	end

	assign code = face[sq_idx];

	////////////////////////////////////////////////////////////
	// colour table, led byte order g r b
	////////////////////////////////////////////////////////////

	always_comb begin
		if (blank) begin
			color = 24'h000000;
		end else begin
			case (code)
				3'd0:    color = 24'h00b000;  // red
				3'd1:    color = 24'h00f060;  // orange
				3'd2:    color = 24'h00b0b0;  // yellow
				3'd3:    color = 24'h0000b0;  // green
				3'd4:    color = 24'hb00000;  // blue
				3'd5:    color = 24'hb05000;  // purple
				default: color = 24'h000000;  // codes 6, 7 unused
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/ws2812_encoder.sv */
// ws2812 pulse encoder: 24 bits per pixel lsb first, closing latch gap after last pixel
`timescale 1ns/1ps
`default_nettype none
`include "cube_config.svh"

module ws2812_encoder (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 pixel_start,
	input  cube_pkg::pixel_cmd_t cmd,
	output logic                 datastream,
	output logic                 pixel_done
);

	typedef enum logic [2:0] {
		idle,   // after reset or latch
		high,   // high part of a bit
		low,    // low part of a bit
		gap,    // one cycle stretch between pixels
		latch   // end of frame reset gap
	} state_t;

	state_t                     state;
	cube_pkg::pixel_cmd_t       cmd_q;      // current pixel
	logic [4:0]                 bit_idx;    // 0..23
	logic [`PULSE_CNT_BITS-1:0] pulse_cnt;  // cycles into the phase
	logic [`PULSE_CNT_BITS-1:0] phase_len;
	logic                       cur_bit, phase_end, last_bit, accept;

	assign cur_bit  = cmd_q.color[bit_idx];
	assign last_bit = (bit_idx == 5'(`COLOR_BITS - 1));
	assign accept   = pixel_start && ((state == idle) || (state == gap));

	////////////////////////////////////////////////////////////
	// phase length from the current bit
	////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			high:    phase_len = cur_bit ? `PULSE_CNT_BITS'(`T1H_CYCLES) :
			                               `PULSE_CNT_BITS'(`T0H_CYCLES);
			low:     phase_len = cur_bit ? `PULSE_CNT_BITS'(`T1L_CYCLES) :
			                               `PULSE_CNT_BITS'(`T0L_CYCLES);
			latch:   phase_len = `PULSE_CNT_BITS'(`LATCH_CYCLES);
			default: phase_len = `PULSE_CNT_BITS'(1);
		endcase
	end

	assign phase_end = (pulse_cnt == phase_len - 1'b1);

	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= idle;
			bit_idx   <= '0;
			pulse_cnt <= '0;
		end else begin
			case (state)
				idle, gap: begin
					if (accept) begin
						state     <= high;  // line goes high the cycle after start
						bit_idx   <= '0;
						pulse_cnt <= '0;
					end else begin
						state <= idle;
					end
				end
				high: begin
					pulse_cnt <= phase_end ? '0 : pulse_cnt + 1'b1;
					if (phase_end)
						state <= low;
				end
				low: begin
					pulse_cnt <= phase_end ? '0 : pulse_cnt + 1'b1;
					if (phase_end) begin
						if (!last_bit) begin
							bit_idx <= bit_idx + 5'd1;
							state   <= high;
						end else if (cmd_q.last) begin
							state <= latch;
						end else begin
							state <= gap;  // next pixel_start lands here
						end
					end
				end
				latch: begin
					pulse_cnt <= phase_end ? '0 : pulse_cnt + 1'b1;
					if (phase_end)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// done on the final low cycle, or the final latch cycle for the last pixel
	assign pixel_done = ((state == low) && phase_end && last_bit && !cmd_q.last) ||
	                    ((state == latch) && phase_end);

	assign datastream = (state == high);

endmodule

`default_nettype wire

/* logic/cube_display_top.sv */
// top level: serial receiver, frame sequencer, square colour map and ws2812 encoder
`timescale 1ns/1ps
`default_nettype none

module cube_display_top (
	input  logic clk,
	input  logic reset,
	input  logic sck,
	input  logic sdi,
	input  logic load,
	output logic datastream,
	output logic busy
);

	cube_pkg::cube_state_u cube_state;  // held between frames
	cube_pkg::face_t       face;        // face under the walk
	cube_pkg::pixel_pos_t  pos;
	cube_pkg::pixel_cmd_t  cmd;
	logic [23:0]           color;
	logic                  frame_start, pixel_start, pixel_done, cmd_last;

	cube_spi_rx spi_rx_i (
		.clk, .reset, .sck, .sdi, .load, .busy,
		.cube_state, .frame_start
	);

	frame_sequencer seq_i (
		.clk, .reset, .frame_start, .pixel_done, .cube_state,
		.face, .pos, .pixel_start, .busy, .cmd_last
	);

	square_color_map map_i (.face, .pos, .color);

	// colour from the map plus end of frame flag from the sequencer
	assign cmd.color = color;
	assign cmd.last  = cmd_last;

	ws2812_encoder enc_i (
		.clk, .reset, .pixel_start, .cmd,
		.datastream, .pixel_done
	);

endmodule

`default_nettype wire

/* dv/ws2812_decoder.sv */
// ws2812 line decoder: high time measurement, bit classification, 24-bit pixel rebuild
`timescale 1ns/1ps
`default_nettype none
`include "cube_config.svh"

module ws2812_decoder (
	input  logic        clk,
	input  logic        reset,
	input  logic        datastream,
	output logic        pix_valid,     // one cycle, pix_word holds a fresh pixel
	output logic [23:0] pix_word,
	output logic        frame_end,     // low gap reached latch length
	output int          frame_pixels,  // pixels seen in the frame that just ended
	output logic        bad_pulse      // one cycle per malformed pulse or pixel
);

	int          high_cnt, low_cnt;  // samples of the current level
	int          pix_cnt;            // pixels in the running frame
	logic [4:0]  bit_cnt;            // bits of the running pixel
	logic [23:0] shift;

	always_ff @(posedge clk) begin
		pix_valid <= 1'b0;
		frame_end <= 1'b0;
		bad_pulse <= 1'b0;
		if (reset) begin
			high_cnt     <= 0;
			low_cnt      <= 0;
			pix_cnt      <= 0;
			bit_cnt      <= '0;
			frame_pixels <= 0;
		end else if (datastream) begin
			high_cnt <= high_cnt + 1;
			low_cnt  <= 0;
		end else begin
			if (low_cnt < `LATCH_CYCLES)
				low_cnt <= low_cnt + 1;  // saturates, long idle is still one gap
			// falling edge, classify the pulse that just ended
			if (high_cnt != 0) begin
				high_cnt <= 0;
				if (high_cnt == `T1H_CYCLES || high_cnt == `T0H_CYCLES) begin
					if (bit_cnt == 5'd23) begin
						pix_word  <= {high_cnt == `T1H_CYCLES, shift[22:0]};  // lsb first
						pix_valid <= 1'b1;
						bit_cnt   <= '0;
						pix_cnt   <= pix_cnt + 1;
					end else begin
						shift[bit_cnt] <= (high_cnt == `T1H_CYCLES);
						bit_cnt        <= bit_cnt + 5'd1;
					end
				end else begin
					$display("decoder: high pulse of %0d cycles is neither a 0 nor a 1 bit",
					         high_cnt);
					bad_pulse <= 1'b1;
				end
			end
			// end of frame once the line has been low for the latch time
			if (low_cnt == `LATCH_CYCLES - 1 && (pix_cnt != 0 || bit_cnt != 0)) begin
				frame_end    <= 1'b1;
				frame_pixels <= pix_cnt;
				pix_cnt      <= 0;
				bit_cnt      <= '0;
				if (bit_cnt != 0) begin
					$display("decoder: frame ended in the middle of a pixel after %0d bits",
					         bit_cnt);
					bad_pulse <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* dv/cube_display_tb.sv */
// testbench top: clock, reset, serial load driver, golden reader, frame checks, watchdog
`timescale 1ns/1ps
`default_nettype none
`include "cube_config.svh"

module cube_display_tb;

	localparam int num_tests    = 2;
	localparam int frame_pixels = `CUBE_FACES * `PANEL_SIZE * `PANEL_SIZE;  // 384
	localparam int frame_cycles = frame_pixels * `COLOR_BITS * 52 + `LATCH_CYCLES +
	                              `CUBE_BITS * 8;
	localparam int watchdog_cycles = 2 * (num_tests + 1) * frame_cycles;

	logic clk, reset, sck, sdi, load;
	logic datastream, busy;
	logic pix_valid, frame_end, bad_pulse;
	logic [23:0] pix_word;
	int          dec_pixels;

	logic [`CUBE_BITS-1:0] states [num_tests];           // cube state per test
	logic [23:0]           golden [num_tests][`CUBE_FACES][`FACE_SQUARES];
	int                    short_bits;                    // length of the rejected load
	logic [23:0]           got_q [$];                     // decoded pixels of a frame
	int                    errors, checks;
	bit                    frame_seen, golden_ok;
	logic [31:0]           rng;

	cube_display_top dut_i (.clk, .reset, .sck, .sdi, .load, .datastream, .busy);

	ws2812_decoder dec_i (
		.clk, .reset, .datastream, .pix_valid, .pix_word, .frame_end,
		.frame_pixels(dec_pixels), .bad_pulse
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns
	end

	always @(posedge clk) begin
		if (pix_valid)
			got_q.push_back(pix_word);
		if (frame_end)
			frame_seen = 1'b1;
		if (bad_pulse)
			errors++;  // decoder already said what was wrong
	end

	//////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got,
	                           input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// colour of pixel p of face f, straight from the serpentine and divider rules
	function automatic logic [23:0] expected_color(input int t, input int f, input int p);
		int col, row, bc, br, sq;
		col = p / `PANEL_SIZE;
		row = (col % 2 == 0) ? p % `PANEL_SIZE : `PANEL_SIZE - 1 - p % `PANEL_SIZE;
		if (row == `DIVIDER_A || row == `DIVIDER_B || col == `DIVIDER_A || col == `DIVIDER_B)
			return 24'h000000;
		bc = col / 3;
		br = row / 3;
		sq = (bc % 2 == 0) ? 3 * bc + br : 3 * bc + 2 - br;
		return golden[t][f][sq];
	endfunction

	// next line that is not blank and not a # comment
	task automatic next_line(input int fd, output string line);
		int rc;
		line = "";
		while (line == "" && !$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
				line = "";
		end
	endtask

	task automatic read_golden(output bit ok);
		int    fd, t, f, n;
		string line;
		ok = 1'b1;
		fd = $fopen("dv/cube_display_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file dv/cube_display_golden.txt");
			errors++;
			ok = 1'b0;
			return;
		end
		for (t = 0; t < num_tests; t++) begin
			next_line(fd, line);
			n = $sscanf(line, "%h", states[t]);
			if (n != 1)
				ok = 1'b0;
			for (f = 0; f < `CUBE_FACES; f++) begin
				next_line(fd, line);
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
				            golden[t][f][0], golden[t][f][1], golden[t][f][2],
				            golden[t][f][3], golden[t][f][4], golden[t][f][5],
				            golden[t][f][6], golden[t][f][7], golden[t][f][8]);
				if (n != `FACE_SQUARES)
					ok = 1'b0;
			end
		end
		next_line(fd, line);
		n = $sscanf(line, "%d", short_bits);  // bit count of the rejected load
		if (n != 1)
			ok = 1'b0;
		$fclose(fd);
		if (!ok) begin
			$display("the golden file is malformed");
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////

	// sck period is 8 clk, sdi moves on the falling sck edge
	task automatic send_load(input logic [`CUBE_BITS-1:0] word, input int nbits);
		int i;
		@(posedge clk);
		load <= 1'b1;
		repeat (4) @(posedge clk);
		for (i = 0; i < nbits; i++) begin
			sdi <= word[`CUBE_BITS-1-i];  // msb first
			repeat (4) @(posedge clk);
			sck <= 1'b1;
			repeat (4) @(posedge clk);
			sck <= 1'b0;
		end
		repeat (4) @(posedge clk);
		load <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (busy !== level) begin
			errors++;
			$display("busy did not go to %0d within %0d cycles", level, limit);
		end
	endtask

	task automatic idle_gap();
		rng = xorshift32(rng);
		repeat (16 + rng % 64) @(posedge clk);
	endtask

	task automatic run_frame(input int t);
		int i;
		got_q.delete();
		frame_seen = 1'b0;
		send_load(states[t], `CUBE_BITS);
		wait_busy(1'b1, 50);
		wait_busy(1'b0, frame_cycles);
		check_value("frame_end before busy fall", frame_seen, 1);  // latch gap was long enough
		check_value("decoder frame_pixels", dec_pixels, frame_pixels);
		check_value("decoded pixel count", got_q.size(), frame_pixels);
		for (i = 0; i < got_q.size() && i < frame_pixels; i++)
			check_value($sformatf("pix_word test %0d face %0d pixel %0d", t, i / 64, i % 64),
			            got_q[i], expected_color(t, i / 64, i % 64));
	endtask

	// short load, nothing may move for a whole frame time
	task automatic reject_load();
		bit seen_busy, seen_high;
		int n;
		seen_busy = 1'b0;
		seen_high = 1'b0;
		send_load(states[0], short_bits);
		for (n = 0; n < frame_cycles; n++) begin
			@(posedge clk);
			seen_busy |= busy;
			seen_high |= datastream;
		end
		check_value("busy after short load", seen_busy, 0);
		check_value("datastream after short load", seen_high, 0);
	endtask

	//////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////

	initial begin
		int n;
		errors = 0;
		checks = 0;
		rng    = 32'd70;
		reset <= 1'b1;
		sck   <= 1'b0;
		sdi   <= 1'b0;
		load  <= 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		read_golden(golden_ok);
		if (golden_ok) begin
			rng = xorshift32(rng);
			for (n = 0; n < 16 + rng % 64; n++) begin  // quiet after reset
				@(posedge clk);
				check_value("datastream", datastream, 0);
				check_value("busy", busy, 0);
			end
			run_frame(0);
			idle_gap();
			reject_load();
			idle_gap();
			run_frame(1);  // held state must be replaced
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout, the run did not finish within %0d clock cycles", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/cube_pkg.sv
logic/cube_spi_rx.sv
logic/frame_sequencer.sv
logic/square_color_map.sv
logic/ws2812_encoder.sv
logic/cube_display_top.sv
dv/ws2812_decoder.sv
dv/cube_display_tb.sv

/* dv/cube_display_golden.txt */
# per test: cube state as 41 hex digits (first bit sent is bit 161), then faces 0..5,
# one line each with the hex colours of squares 0..8; last line: bit count of a rejected load
08688688688688688688688688688688688688688
00b000 00f060 00b0b0 0000b0 00b000 00f060 00b0b0 0000b0 00b000
00f060 00b0b0 0000b0 00b000 00f060 00b0b0 0000b0 00b000 00f060
00b0b0 0000b0 00b000 00f060 00b0b0 0000b0 00b000 00f060 00b0b0
0000b0 00b000 00f060 00b0b0 0000b0 00b000 00f060 00b0b0 0000b0
00b000 00f060 00b0b0 0000b0 00b000 00f060 00b0b0 0000b0 00b000
00f060 00b0b0 0000b0 00b000 00f060 00b0b0 0000b0 00b000 00f060
37977977977977977977977977977977977977977
000000 000000 b05000 b00000 000000 000000 b05000 b00000 000000
000000 b05000 b00000 000000 000000 b05000 b00000 000000 000000
b05000 b00000 000000 000000 b05000 b00000 000000 000000 b05000
b00000 000000 000000 b05000 b00000 000000 000000 b05000 b00000
000000 000000 b05000 b00000 000000 000000 b05000 b00000 000000
000000 b05000 b00000 000000 000000 b05000 b00000 000000 000000
161
